// ==== build.f ====
hw/lsu_pkg.sv
hw/lsu_issue.sv
hw/lsu_bus_master.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
tb/lsu_mem_model.sv
tb/lsu_sva.sv
tb/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run for the load/store stage testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= lsu_tb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb/lsu_tb.sv ====
// testbench: clock, reset, random requests, memory model, result checks and watchdog
`timescale 1ns/10ps

module lsu_tb import lsu_pkg::*; ();

	localparam int num_reqs     = 400;
	localparam int clk_period   = 40;
	localparam int mem_words    = 64;
	localparam int err_word     = 48;
	localparam int reset_cycles = 3;
	localparam int seed_value   = 32'hf5ed_e81b;

	logic                clk = 1'b0;
	logic                reset;
	logic                req_valid;
	logic                req_ready;
	logic [1:0]          req_op;
	logic [2:0]          req_width;
	logic [31:0]         req_addr;
	logic [31:0]         req_wdata;
	logic [tag_bits-1:0] req_tag;
	logic                arvalid;
	logic                arready;
	logic                rvalid;
	logic                rready;
	logic [31:0]         araddr;
	logic [31:0]         rdata;
	logic [31:0]         awaddr;
	logic [31:0]         wdata;
	logic [2:0]          arsize;
	logic [2:0]          awsize;
	logic [1:0]          rresp;
	logic [1:0]          bresp;
	logic                awvalid;
	logic                awready;
	logic                wvalid;
	logic                wready;
	logic                bvalid;
	logic                bready;
	logic [3:0]          wstrb;
	logic                wb_valid;
	logic                wb_ready;
	logic [31:0]         wb_data;
	logic [tag_bits-1:0] wb_tag;
	logic                wb_err;

	integer              seed;
	logic [31:0]         model_mem [0:mem_words-1];
	logic [31:0]         exp_data[$];
	logic [tag_bits-1:0] exp_tag[$];
	logic                exp_err[$];
	logic [2:0]          exp_ar_size[$];
	logic [2:0]          exp_aw_size[$];
	logic                req_taken;
	int                  sent;
	int                  loads;
	int                  stores;
	int                  ar_count;
	int                  aw_count;
	logic [2:0]          widths [0:4];

	lsu_top UUT (.*);

	lsu_mem_model #(.seed_init(seed_value)) slave (
		.clk(clk), .reset(reset),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp)
	);

	always #(clk_period / 2) clk = ~clk;

	// handshakes counted where the bus is stable
	// bus sizes follow the accepted requests in order
	always @(negedge clk) begin
		logic [2:0] want_size;
		if (!reset && arvalid && arready) begin
			ar_count++;
			want_size = exp_ar_size.pop_front();
			assert (arsize == want_size)
				else report_failure($sformatf("FAILED arsize got %0h expected %0h",
					arsize, want_size));
		end
		if (!reset && awvalid && awready) begin
			aw_count++;
			want_size = exp_aw_size.pop_front();
			assert (awsize == want_size)
				else report_failure($sformatf("FAILED awsize got %0h expected %0h",
					awsize, want_size));
		end
	end

	initial begin
		#(num_reqs * 40 * clk_period);
		$display("timeout: requests did not complete in time");
		$display("Test failures found");
		$fatal(1, "watchdog expired");
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopping at first error");
	endtask

	// distinct value per word from every address bit
	function automatic logic [31:0] fill_word(input int i);
		logic [7:0] a;
		a = i[7:0];
		return {a ^ 8'h3c, a * 8'd7, ~a, a * 8'd13 + 8'd5};
	endfunction

	// expected result of an accepted request, memory updated in order
	task automatic accept_request();
		logic [5:0]  idx;
		logic [1:0]  off;
		logic [3:0]  strb;
		logic [2:0]  size;
		logic [31:0] lanes;
		logic [31:0] word;
		logic [31:0] shifted;
		logic [31:0] expect_val;
		logic        err;
		idx = req_addr[7:2];
		off = req_addr[1:0];
		err = (idx >= err_word);
		expect_val = 32'h0;
		// one, two or four bytes
		case (req_width)
			w_byte, w_byte_u: size = size_byte;
			w_half, w_half_u: size = size_half;
			default:          size = size_word;
		endcase
		case (req_op)
			op_store: begin
				case (req_width)
					w_byte, w_byte_u: strb = 4'b0001 << off;
					w_half, w_half_u: strb = (off == 2'd3) ? 4'b0000 : 4'b0011 << off;
					default:          strb = (off == 2'd0) ? 4'b1111 : 4'b0000;
				endcase
				lanes = req_wdata << (8 * off);
				for (int b = 0; b < 4; b++) begin
					if (!err && strb[b])
						model_mem[idx][b*8 +: 8] = lanes[b*8 +: 8];
				end
				exp_aw_size.push_back(size);
				stores++;
			end
			op_load: begin
				word = err ? 32'h0 : model_mem[idx];
				shifted = word >> (8 * off);
				case (req_width)
					w_byte:   expect_val = {{24{shifted[7]}}, shifted[7:0]};
					w_byte_u: expect_val = {24'h0, shifted[7:0]};
					w_half:   expect_val = {{16{shifted[15]}}, shifted[15:0]};
					w_half_u: expect_val = {16'h0, shifted[15:0]};
					default:  expect_val = shifted;
				endcase
				exp_ar_size.push_back(size);
				loads++;
			end
			default: begin
				expect_val = req_addr;
				err = 1'b0;
			end
		endcase
		exp_data.push_back(expect_val);
		exp_tag.push_back(req_tag);
		exp_err.push_back(err);
	endtask

	task automatic check_result();
		assert (exp_data.size() > 0)
			else report_failure("writeback seen with no request outstanding");
		assert (wb_tag == exp_tag[0])
			else report_failure($sformatf("FAILED wb_tag got %0h expected %0h",
				wb_tag, exp_tag[0]));
		assert (wb_data == exp_data[0])
			else report_failure($sformatf("FAILED wb_data got %08h expected %08h",
				wb_data, exp_data[0]));
		assert (wb_err == exp_err[0])
			else report_failure($sformatf("FAILED wb_err got %0h expected %0h",
				wb_err, exp_err[0]));
		void'(exp_data.pop_front());
		void'(exp_tag.pop_front());
		void'(exp_err.pop_front());
	endtask

	task automatic new_request();
		int r;
		r = $random(seed) & 7;
		req_op    = (r < 3) ? op_store : (r < 6) ? op_load : op_none;
		req_width = widths[($random(seed) & 32'h7fff_ffff) % 5];
		req_addr  = (req_op == op_none) ? $random(seed) : {24'h0, 8'($random(seed))};
		req_wdata = $random(seed);
		req_tag   = tag_bits'(sent);
		req_valid = 1'b1;
	endtask

	initial begin
		seed = seed_value;
		widths[0] = w_byte;
		widths[1] = w_half;
		widths[2] = w_word;
		widths[3] = w_byte_u;
		widths[4] = w_half_u;
		reset     = 1'b1;
		req_valid = 1'b0;
		req_op    = op_none;
		req_width = w_word;
		req_addr  = 32'h0;
		req_wdata = 32'h0;
		req_tag   = '0;
		wb_ready  = 1'b0;
		req_taken = 1'b0;
		sent = 0;
		loads = 0;
		stores = 0;
		ar_count = 0;
		aw_count = 0;
		for (int i = 0; i < mem_words; i++) begin
			model_mem[i] = fill_word(i);
			slave.mem[i] = fill_word(i);
		end

		repeat (reset_cycles) @(posedge clk);
		#1 reset = 1'b0;
		@(negedge clk);
		assert (!wb_valid && !arvalid && !awvalid && !wvalid && !rready && !bready
			&& !req_ready)
			else report_failure("outputs not idle after reset");

		while (sent < num_reqs || exp_data.size() > 0) begin
			@(negedge clk);
			// the DUT takes the request on the coming edge
			req_taken = req_valid && req_ready;
			if (req_taken) begin
				accept_request();
				sent++;
			end
			if (wb_valid && wb_ready)
				check_result();
			@(posedge clk);
			#1;
			if (req_taken)
				req_valid = 1'b0;
			// drain freely once every request is in
			wb_ready = (sent >= num_reqs) ? 1'b1 : (($random(seed) & 3) != 0);
			if (!req_valid && sent < num_reqs && (($random(seed) & 3) != 0))
				new_request();
		end

		@(negedge clk);
		assert (ar_count == loads)
			else report_failure($sformatf("FAILED ar handshakes got %0h expected %0h",
				ar_count, loads));
		assert (aw_count == stores)
			else report_failure($sformatf("FAILED aw handshakes got %0h expected %0h",
				aw_count, stores));
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== tb/lsu_sva.sv ====
// bus master handshake assertions and their bind
`timescale 1ns/10ps

module lsu_sva (
	input logic clk,
	input logic reset,
	input logic arvalid,
	input logic arready,
	input logic awvalid,
	input logic awready,
	input logic wvalid,
	input logic wready
);

	// a valid stays up until its ready
	ar_hold: assert property (@(posedge clk) disable iff (reset)
		arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	aw_hold: assert property (@(posedge clk) disable iff (reset)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before awready");

	w_hold: assert property (@(posedge clk) disable iff (reset)
		wvalid && !wready |=> wvalid)
		else $error("wvalid dropped before wready");

endmodule

bind lsu_bus_master lsu_sva u_sva (
	.clk     (clk),
	.reset   (reset),
	.arvalid (arvalid),
	.arready (arready),
	.awvalid (awvalid),
	.awready (awready),
	.wvalid  (wvalid),
	.wready  (wready)
);

// ==== tb/lsu_mem_model.sv ====
// AXI slave memory for the testbench: random ready delays, error region at the top
`timescale 1ns/10ps

module lsu_mem_model #(
	parameter int seed_init = 0
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        arvalid,
	output logic        arready,
	input  logic [31:0] araddr,
	output logic        rvalid,
	input  logic        rready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] awaddr,
	input  logic        wvalid,
	output logic        wready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic        bvalid,
	input  logic        bready,
	output logic [1:0]  bresp
);

	localparam int err_word = 48;
	localparam logic [1:0] resp_slverr = 2'b10;

	// filled by the testbench at time zero
	logic [31:0] mem [0:63];

	integer      seed;
	int          ar_wait;
	int          aw_wait;
	int          w_wait;
	logic        got_aw;
	logic        got_w;
	logic [5:0]  wr_idx;
	logic [31:0] w_data_q;
	logic [3:0]  w_strb_q;

	initial seed = seed_init;

	always @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			rdata   <= 32'h0;
			rresp   <= 2'b00;
			bresp   <= 2'b00;
			ar_wait <= 0;
			aw_wait <= 0;
			w_wait  <= 0;
			got_aw  <= 1'b0;
			got_w   <= 1'b0;
		end else begin
			// read address, then one data beat
			if (arvalid && arready) begin
				arready <= 1'b0;
				ar_wait <= $random(seed) & 3;
				rvalid  <= 1'b1;
				if (araddr[7:2] >= err_word) begin
					rdata <= 32'h0;
					rresp <= resp_slverr;
				end else begin
					rdata <= mem[araddr[7:2]];
					rresp <= 2'b00;
				end
			end else if (arvalid) begin
				if (ar_wait == 0)
					arready <= 1'b1;
				else
					ar_wait <= ar_wait - 1;
			end
			if (rvalid && rready)
				rvalid <= 1'b0;

			// write address and data arrive independently
			if (awvalid && awready) begin
				awready <= 1'b0;
				aw_wait <= $random(seed) & 3;
				got_aw  <= 1'b1;
				wr_idx  <= awaddr[7:2];
			end else if (awvalid) begin
				if (aw_wait == 0)
					awready <= 1'b1;
				else
					aw_wait <= aw_wait - 1;
			end
			if (wvalid && wready) begin
				wready   <= 1'b0;
				w_wait   <= $random(seed) & 3;
				got_w    <= 1'b1;
				w_data_q <= wdata;
				w_strb_q <= wstrb;
			end else if (wvalid) begin
				if (w_wait == 0)
					wready <= 1'b1;
				else
					w_wait <= w_wait - 1;
			end

			if (got_aw && got_w && !bvalid) begin
				if (wr_idx < err_word) begin
					for (int b = 0; b < 4; b++) begin
						if (w_strb_q[b])
							mem[wr_idx][b*8 +: 8] <= w_data_q[b*8 +: 8];
					end
					bresp <= 2'b00;
				end else begin
					bresp <= resp_slverr;
				end
				bvalid <= 1'b1;
				got_aw <= 1'b0;
				got_w  <= 1'b0;
			end
			if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

endmodule

// ==== hw/lsu_top.sv ====
// load/store stage top: issue, bus master and load aligner in a chain
`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                req_valid,
	output logic                req_ready,
	input  logic [1:0]          req_op,
	input  logic [2:0]          req_width,
	input  logic [31:0]         req_addr,
	input  logic [31:0]         req_wdata,
	input  logic [tag_bits-1:0] req_tag,
	output logic                arvalid,
	input  logic                arready,
	output logic [31:0]         araddr,
	output logic [2:0]          arsize,
	input  logic                rvalid,
	output logic                rready,
	input  logic [31:0]         rdata,
	input  logic [1:0]          rresp,
	output logic                awvalid,
	input  logic                awready,
	output logic [31:0]         awaddr,
	output logic [2:0]          awsize,
	output logic                wvalid,
	input  logic                wready,
	output logic [31:0]         wdata,
	output logic [3:0]          wstrb,
	input  logic                bvalid,
	output logic                bready,
	input  logic [1:0]          bresp,
	output logic                wb_valid,
	input  logic                wb_ready,
	output logic [31:0]         wb_data,
	output logic [tag_bits-1:0] wb_tag,
	output logic                wb_err
);

	// issue to bus master
	logic                iss_valid;
	logic                iss_ready;
	logic [1:0]          iss_op;
	logic [2:0]          iss_width;
	logic [31:0]         iss_addr;
	logic [31:0]         iss_wdata;
	logic [2:0]          iss_size;
	logic [3:0]          iss_strb;
	logic [1:0]          iss_offset;
	logic [tag_bits-1:0] iss_tag;

	// bus master to aligner
	logic                acc_valid;
	logic                acc_ready;
	logic [1:0]          acc_op;
	logic [2:0]          acc_width;
	logic [1:0]          acc_offset;
	logic [31:0]         acc_rdata;
	logic [31:0]         acc_addr;
	logic                acc_err;
	logic [tag_bits-1:0] acc_tag;

	lsu_issue u_issue (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_op     (req_op),
		.req_width  (req_width),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.req_tag    (req_tag),
		.iss_valid  (iss_valid),
		.iss_ready  (iss_ready),
		.iss_op     (iss_op),
		.iss_width  (iss_width),
		.iss_addr   (iss_addr),
		.iss_wdata  (iss_wdata),
		.iss_size   (iss_size),
		.iss_strb   (iss_strb),
		.iss_offset (iss_offset),
		.iss_tag    (iss_tag)
	);

	lsu_bus_master u_bus_master (
		.clk        (clk),
		.reset      (reset),
		.iss_valid  (iss_valid),
		.iss_ready  (iss_ready),
		.iss_op     (iss_op),
		.iss_width  (iss_width),
		.iss_addr   (iss_addr),
		.iss_wdata  (iss_wdata),
		.iss_size   (iss_size),
		.iss_strb   (iss_strb),
		.iss_offset (iss_offset),
		.iss_tag    (iss_tag),
		.arvalid    (arvalid),
		.arready    (arready),
		.araddr     (araddr),
		.arsize     (arsize),
		.rvalid     (rvalid),
		.rready     (rready),
		.rdata      (rdata),
		.rresp      (rresp),
		.awvalid    (awvalid),
		.awready    (awready),
		.awaddr     (awaddr),
		.awsize     (awsize),
		.wvalid     (wvalid),
		.wready     (wready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.bvalid     (bvalid),
		.bready     (bready),
		.bresp      (bresp),
		.acc_valid  (acc_valid),
		.acc_ready  (acc_ready),
		.acc_op     (acc_op),
		.acc_width  (acc_width),
		.acc_offset (acc_offset),
		.acc_rdata  (acc_rdata),
		.acc_addr   (acc_addr),
		.acc_err    (acc_err),
		.acc_tag    (acc_tag)
	);

	lsu_load_align u_load_align (
		.clk        (clk),
		.reset      (reset),
		.acc_valid  (acc_valid),
		.acc_ready  (acc_ready),
		.acc_op     (acc_op),
		.acc_width  (acc_width),
		.acc_offset (acc_offset),
		.acc_rdata  (acc_rdata),
		.acc_addr   (acc_addr),
		.acc_err    (acc_err),
		.acc_tag    (acc_tag),
		.wb_valid   (wb_valid),
		.wb_ready   (wb_ready),
		.wb_data    (wb_data),
		.wb_tag     (wb_tag),
		.wb_err     (wb_err)
	);

endmodule

// ==== hw/lsu_load_align.sv ====
// load aligner: shifts and extends read data, holds the writeback result
`timescale 1ns/10ps

module lsu_load_align import lsu_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                acc_valid,
	output logic                acc_ready,
	input  logic [1:0]          acc_op,
	input  logic [2:0]          acc_width,
	input  logic [1:0]          acc_offset,
	input  logic [31:0]         acc_rdata,
	input  logic [31:0]         acc_addr,
	input  logic                acc_err,
	input  logic [tag_bits-1:0] acc_tag,
	output logic                wb_valid,
	input  logic                wb_ready,
	output logic [31:0]         wb_data,
	output logic [tag_bits-1:0] wb_tag,
	output logic                wb_err
);

	rd_word_t    shifted;
	logic [31:0] load_val;
	logic [31:0] result;
	logic        take;

	assign acc_ready = ~wb_valid | wb_ready;
	assign take      = acc_valid & acc_ready;

	always_comb begin
		// requested byte lands in lane 0
		shifted = acc_rdata >> {acc_offset, 3'b000};
		case (acc_width)
			w_byte:   load_val = {{24{shifted.bytes[0][7]}}, shifted.bytes[0]};
			w_byte_u: load_val = {24'h0, shifted.bytes[0]};
			w_half:   load_val = {{16{shifted.halves[0][15]}}, shifted.halves[0]};
			w_half_u: load_val = {16'h0, shifted.halves[0]};
			default:  load_val = shifted;
		endcase
		case (acc_op)
			op_load:  result = load_val;
			op_store: result = 32'h0;
			// no memory access, the ALU result goes on
			default:  result = acc_addr;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else if (take) begin
			wb_valid <= 1'b1;
		end else if (wb_ready) begin
			wb_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			wb_data <= result;
			wb_tag  <= acc_tag;
			wb_err  <= acc_err;
		end
	end

endmodule

// ==== hw/lsu_bus_master.sv ====
// bus master: FSM running one single-beat AXI read or write per issued request
`timescale 1ns/10ps

module lsu_bus_master import lsu_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                iss_valid,
	output logic                iss_ready,
	input  logic [1:0]          iss_op,
	input  logic [2:0]          iss_width,
	input  logic [31:0]         iss_addr,
	input  logic [31:0]         iss_wdata,
	input  logic [2:0]          iss_size,
	input  logic [3:0]          iss_strb,
	input  logic [1:0]          iss_offset,
	input  logic [tag_bits-1:0] iss_tag,
	output logic                arvalid,
	input  logic                arready,
	output logic [31:0]         araddr,
	output logic [2:0]          arsize,
	input  logic                rvalid,
	output logic                rready,
	input  logic [31:0]         rdata,
	input  logic [1:0]          rresp,
	output logic                awvalid,
	input  logic                awready,
	output logic [31:0]         awaddr,
	output logic [2:0]          awsize,
	output logic                wvalid,
	input  logic                wready,
	output logic [31:0]         wdata,
	output logic [3:0]          wstrb,
	input  logic                bvalid,
	output logic                bready,
	input  logic [1:0]          bresp,
	output logic                acc_valid,
	input  logic                acc_ready,
	output logic [1:0]          acc_op,
	output logic [2:0]          acc_width,
	output logic [1:0]          acc_offset,
	output logic [31:0]         acc_rdata,
	output logic [31:0]         acc_addr,
	output logic                acc_err,
	output logic [tag_bits-1:0] acc_tag
);

	logic [2:0] state;
	logic [2:0] size_q;
	logic       take;
	logic       aw_left;
	logic       w_left;

	assign iss_ready = (state == st_idle);
	assign take      = iss_valid & iss_ready;

	// the bus only sees word-aligned addresses
	assign araddr = {acc_addr[31:2], 2'b00};
	assign awaddr = {acc_addr[31:2], 2'b00};
	assign arsize = size_q;
	assign awsize = size_q;

	// channels still waiting for their ready after this cycle
	assign aw_left = awvalid & ~awready;
	assign w_left  = wvalid & ~wready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			arvalid   <= 1'b0;
			rready    <= 1'b0;
			awvalid   <= 1'b0;
			wvalid    <= 1'b0;
			bready    <= 1'b0;
			acc_valid <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (take) begin
						case (iss_op)
							op_load: begin
								arvalid <= 1'b1;
								state   <= st_rd_addr;
							end
							op_store: begin
								awvalid <= 1'b1;
								wvalid  <= 1'b1;
								state   <= st_write;
							end
							default: begin
								acc_valid <= 1'b1;
								state     <= st_done;
							end
						endcase
					end
				end
				st_rd_addr: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						state   <= st_rd_data;
					end
				end
				st_rd_data: begin
					if (rvalid) begin
						rready    <= 1'b0;
						acc_valid <= 1'b1;
						state     <= st_done;
					end
				end
				st_write: begin
					if (awready) begin
						awvalid <= 1'b0;
					end
					if (wready) begin
						wvalid <= 1'b0;
					end
					if (!aw_left && !w_left) begin
						bready <= 1'b1;
						state  <= st_wr_resp;
					end
				end
				st_wr_resp: begin
					if (bvalid) begin
						bready    <= 1'b0;
						acc_valid <= 1'b1;
						state     <= st_done;
					end
				end
				default: begin
					// result waits here for the aligner
					if (acc_ready) begin
						acc_valid <= 1'b0;
						state     <= st_idle;
					end
				end
			endcase
		end
	end

	// request payload and captured response
	always_ff @(posedge clk) begin
		if (take) begin
			acc_op     <= iss_op;
			acc_width  <= iss_width;
			acc_offset <= iss_offset;
			acc_addr   <= iss_addr;
			acc_tag    <= iss_tag;
			size_q     <= iss_size;
			wdata      <= iss_wdata;
			wstrb      <= iss_strb;
			acc_rdata  <= 32'h0;
			acc_err    <= 1'b0;
		end else if (state == st_rd_data && rvalid) begin
			acc_rdata <= rdata;
			acc_err   <= (rresp != resp_okay);
		end else if (state == st_wr_resp && bvalid) begin
			acc_err <= (bresp != resp_okay);
		end
	end

endmodule

// ==== hw/lsu_issue.sv ====
// issue stage: request register, size decode, byte strobe and store lane placement
`timescale 1ns/10ps

module lsu_issue import lsu_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                req_valid,
	output logic                req_ready,
	input  logic [1:0]          req_op,
	input  logic [2:0]          req_width,
	input  logic [31:0]         req_addr,
	input  logic [31:0]         req_wdata,
	input  logic [tag_bits-1:0] req_tag,
	output logic                iss_valid,
	input  logic                iss_ready,
	output logic [1:0]          iss_op,
	output logic [2:0]          iss_width,
	output logic [31:0]         iss_addr,
	output logic [31:0]         iss_wdata,
	output logic [2:0]          iss_size,
	output logic [3:0]          iss_strb,
	output logic [1:0]          iss_offset,
	output logic [tag_bits-1:0] iss_tag
);

	logic        run;
	logic        take;
	logic [1:0]  offset;
	logic [2:0]  size;
	logic [3:0]  strb;
	logic [31:0] lane_data;

	// held low through reset, opens one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
		end else begin
			run <= 1'b1;
		end
	end

	assign req_ready = run & (~iss_valid | iss_ready);
	assign take      = req_valid & req_ready;
	assign offset    = req_addr[1:0];

	always_comb begin
		case (req_width)
			w_byte, w_byte_u: begin
				size = size_byte;
				strb = 4'b0001 << offset;
			end
			w_half, w_half_u: begin
				size = size_half;
				// a half at offset 3 would leave the word
				strb = (offset == 2'd3) ? 4'b0000 : (4'b0011 << offset);
			end
			default: begin
				size = size_word;
				strb = (offset == 2'd0) ? 4'b1111 : 4'b0000;
			end
		endcase
		lane_data = req_wdata << {offset, 3'b000};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			iss_valid <= 1'b0;
		end else if (take) begin
			iss_valid <= 1'b1;
		end else if (iss_ready) begin
			iss_valid <= 1'b0;
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (take) begin
			iss_op     <= req_op;
			iss_width  <= req_width;
			iss_addr   <= req_addr;
			iss_wdata  <= lane_data;
			iss_size   <= size;
			iss_strb   <= strb;
			iss_offset <= offset;
			iss_tag    <= req_tag;
		end
	end

endmodule

// ==== hw/lsu_pkg.sv ====
// shared constants for the load/store stage: operations, widths, AXI codes, FSM states, read-word union
package lsu_pkg;

	// request operation from execute
	localparam logic [1:0] op_none  = 2'b00;
	localparam logic [1:0] op_load  = 2'b01;
	localparam logic [1:0] op_store = 2'b10;

	// funct3 width codes
	localparam logic [2:0] w_byte   = 3'b000;
	localparam logic [2:0] w_half   = 3'b001;
	localparam logic [2:0] w_word   = 3'b010;
	localparam logic [2:0] w_byte_u = 3'b100;
	localparam logic [2:0] w_half_u = 3'b101;

	// AXI transfer sizes, bytes as a power of two
	localparam logic [2:0] size_byte = 3'b000;
	localparam logic [2:0] size_half = 3'b001;
	localparam logic [2:0] size_word = 3'b010;

	localparam logic [1:0] resp_okay = 2'b00;

	// destination register tag
	localparam int tag_bits = 5;

	// bus master states
	localparam logic [2:0] st_idle    = 3'd0;
	localparam logic [2:0] st_rd_addr = 3'd1;
	localparam logic [2:0] st_rd_data = 3'd2;
	localparam logic [2:0] st_write   = 3'd3;
	localparam logic [2:0] st_wr_resp = 3'd4;
	localparam logic [2:0] st_done    = 3'd5;

	// returned read word, seen as bytes or as halves
	typedef union packed {
		logic [3:0][7:0]  bytes;
		logic [1:0][15:0] halves;
	} rd_word_t;

endpackage
